// ==== rtl/mem_pkg.sv ====
package mem_pkg;

  // request opcodes, loads first.
  typedef enum logic [3:0] {
    LW  = 4'd0,
    LH  = 4'd1,
    LB  = 4'd2,
    LHU = 4'd3,
    LBU = 4'd4,
    SW  = 4'd5,
    SH  = 4'd6,
    SB  = 4'd7
  } op_e;

  typedef logic [31:0] data_t; // one memory word.
  typedef logic [3:0]  mask_t; // one bit per byte lane.

  // stores write the array and answer with zero data.
  function automatic logic is_store(input op_e op);
    case (op)
      SW, SH, SB: return 1'b1;
      default:    return 1'b0;
    endcase
  endfunction

endpackage

// ==== rtl/lane_align.sv ====
module lane_align (
  input  mem_pkg::op_e   op_i,
  input  logic [1:0]     byte_off_i,
  input  mem_pkg::data_t store_data_i,
  output mem_pkg::data_t store_data_o,
  output mem_pkg::mask_t store_mask_o,
  input  mem_pkg::data_t load_word_i,
  output mem_pkg::data_t load_data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // store side, replicate the payload across lanes and mask by offset.
  always_comb begin
    store_data_o = '0;
    store_mask_o = '0;
    case (op_i)
      mem_pkg::SW: begin
        store_data_o = store_data_i;
        store_mask_o = 4'b1111;
      end
      mem_pkg::SH: begin
        store_data_o = {2{store_data_i[15:0]}};
        store_mask_o = byte_off_i[1] ? 4'b1100 : 4'b0011;
      end
      mem_pkg::SB: begin
        store_data_o = {4{store_data_i[7:0]}};
        store_mask_o = 4'b0001 << byte_off_i;
      end
      default: begin
        store_mask_o = '0; // loads write nothing.
      end
    endcase
  end

  // load side.
  assign byte_sel = load_word_i[8*byte_off_i +: 8];
  assign half_sel = load_word_i[16*byte_off_i[1] +: 16];

  always_comb begin
    case (op_i)
      mem_pkg::LW: begin
        load_data_o = load_word_i;
      end
      mem_pkg::LH: begin
        load_data_o = {{16{half_sel[15]}}, half_sel};
      end
      mem_pkg::LB: begin
        load_data_o = {{24{byte_sel[7]}}, byte_sel};
      end
      mem_pkg::LHU: begin
        load_data_o = {16'b0, half_sel};
      end
      mem_pkg::LBU: begin
        load_data_o = {24'b0, byte_sel};
      end
      default: begin
        load_data_o = '0;
      end
    endcase
  end

endmodule

// ==== rtl/client_port.sv ====
module client_port #(
  parameter int addr_width_p    = 12,
  parameter int id_width_p      = 4,
  parameter int pending_depth_p = 4,
  parameter int port_id_p       = 0
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  output logic                    ready_o,
  input  mem_pkg::op_e            op_i,
  input  logic [addr_width_p-1:0] addr_i,
  input  mem_pkg::data_t          data_i,
  input  logic [id_width_p-1:0]   id_i,
  output logic                    v_o,
  input  logic                    yumi_i,
  output logic [id_width_p-1:0]   id_o,
  output mem_pkg::data_t          data_o,
  output logic                    mem_v_o,
  input  logic                    grant_i,
  output logic                    mem_we_o,
  output logic [addr_width_p-3:0] mem_addr_o,
  output mem_pkg::data_t          mem_wdata_o,
  output mem_pkg::mask_t          mem_mask_o,
  input  logic                    rd_v_i,
  input  logic                    rd_src_i,
  input  mem_pkg::data_t          rd_data_i
);

  localparam int ptr_width_lp = (pending_depth_p > 1) ? $clog2(pending_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(pending_depth_p + 1);
  localparam logic [cnt_width_lp-1:0] full_lp = cnt_width_lp'(pending_depth_p);

  logic accept;
  logic issue;
  logic rd_mine;
  logic consume;
  logic [cnt_width_lp-1:0] credit_r;

  mem_pkg::data_t st_data;
  mem_pkg::mask_t st_mask;
  mem_pkg::data_t ld_data;

  logic                    iss_v_r;
  logic                    iss_we_r;
  logic [addr_width_p-3:0] iss_addr_r;
  mem_pkg::data_t          iss_data_r;
  mem_pkg::mask_t          iss_mask_r;
  logic [id_width_p-1:0]   iss_id_r;
  mem_pkg::op_e            iss_op_r;
  logic [1:0]              iss_off_r;

  // pending queue in issue order.
  logic [id_width_p-1:0]   pend_id_q  [pending_depth_p];
  mem_pkg::op_e            pend_op_q  [pending_depth_p];
  logic [1:0]              pend_off_q [pending_depth_p];
  logic [ptr_width_lp-1:0] pend_wr_r;
  logic [ptr_width_lp-1:0] pend_rd_r;
  logic [cnt_width_lp-1:0] pend_cnt_r;

  // result queue toward the client.
  logic [id_width_p-1:0]   res_id_q   [pending_depth_p];
  mem_pkg::data_t          res_data_q [pending_depth_p];
  logic [ptr_width_lp-1:0] res_wr_r;
  logic [ptr_width_lp-1:0] res_rd_r;
  logic [cnt_width_lp-1:0] res_cnt_r;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] p);
    return (p == ptr_width_lp'(pending_depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  // credits cover the issue slot, the pending queue and the result queue.
  assign ready_o = (credit_r != full_lp) & (~iss_v_r | grant_i);
  assign accept  = v_i & ready_o;
  assign issue   = iss_v_r & grant_i;
  assign rd_mine = rd_v_i & (rd_src_i == 1'(port_id_p));
  assign consume = v_o & yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_r <= '0;
    end else begin
      credit_r <= credit_r + cnt_width_lp'(accept) - cnt_width_lp'(consume);
    end
  end

  lane_align u_st_align (
    .op_i         (op_i),
    .byte_off_i   (addr_i[1:0]),
    .store_data_i (data_i),
    .store_data_o (st_data),
    .store_mask_o (st_mask),
    .load_word_i  ('0),
    .load_data_o  ()
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      iss_v_r <= 1'b0;
    end else begin
      iss_v_r <= accept | (iss_v_r & ~grant_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      iss_we_r   <= mem_pkg::is_store(op_i);
      iss_addr_r <= addr_i[addr_width_p-1:2]; // low bits go to the lane logic.
      iss_data_r <= st_data;
      iss_mask_r <= st_mask;
      iss_id_r   <= id_i;
      iss_op_r   <= op_i;
      iss_off_r  <= addr_i[1:0];
    end
  end

  assign mem_v_o     = iss_v_r;
  assign mem_we_o    = iss_we_r;
  assign mem_addr_o  = iss_addr_r;
  assign mem_wdata_o = iss_data_r;
  assign mem_mask_o  = iss_mask_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_wr_r  <= '0;
      pend_rd_r  <= '0;
      pend_cnt_r <= '0;
    end else begin
      if (issue) pend_wr_r <= next_ptr(pend_wr_r);
      if (rd_mine) pend_rd_r <= next_ptr(pend_rd_r);
      pend_cnt_r <= pend_cnt_r + cnt_width_lp'(issue) - cnt_width_lp'(rd_mine);
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      pend_id_q[pend_wr_r]  <= iss_id_r;
      pend_op_q[pend_wr_r]  <= iss_op_r;
      pend_off_q[pend_wr_r] <= iss_off_r;
    end
  end

  lane_align u_ld_align (
    .op_i         (pend_op_q[pend_rd_r]),
    .byte_off_i   (pend_off_q[pend_rd_r]),
    .store_data_i ('0),
    .store_data_o (),
    .store_mask_o (),
    .load_word_i  (rd_data_i),
    .load_data_o  (ld_data)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res_wr_r  <= '0;
      res_rd_r  <= '0;
      res_cnt_r <= '0;
    end else begin
      if (rd_mine) res_wr_r <= next_ptr(res_wr_r);
      if (consume) res_rd_r <= next_ptr(res_rd_r);
      res_cnt_r <= res_cnt_r + cnt_width_lp'(rd_mine) - cnt_width_lp'(consume);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_mine) begin
      res_id_q[res_wr_r]   <= pend_id_q[pend_rd_r];
      res_data_q[res_wr_r] <= mem_pkg::is_store(pend_op_q[pend_rd_r]) ? '0 : ld_data;
    end
  end

  assign v_o    = (res_cnt_r != '0);
  assign id_o   = res_id_q[res_rd_r];
  assign data_o = res_data_q[res_rd_r];

  a_credit_split: assert property (@(posedge clk_i) disable iff (reset_i)
    (credit_r <= full_lp) &&
    (credit_r == cnt_width_lp'(iss_v_r) + pend_cnt_r + res_cnt_r));

  // memory latency is fixed, so a beat always has its pending entry.
  a_beat_has_entry: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_mine |-> (pend_cnt_r != '0));

  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(id_o) && $stable(data_o)));

endmodule

// ==== rtl/rr_arbiter.sv ====
module rr_arbiter #(
  parameter int addr_width_p = 12
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_a_i,
  input  logic                    req_we_a_i,
  input  logic [addr_width_p-3:0] req_addr_a_i,
  input  mem_pkg::data_t          req_wdata_a_i,
  input  mem_pkg::mask_t          req_mask_a_i,
  output logic                    grant_a_o,
  input  logic                    req_v_b_i,
  input  logic                    req_we_b_i,
  input  logic [addr_width_p-3:0] req_addr_b_i,
  input  mem_pkg::data_t          req_wdata_b_i,
  input  mem_pkg::mask_t          req_mask_b_i,
  output logic                    grant_b_o,
  output logic                    v_o,
  output logic                    we_o,
  output logic [addr_width_p-3:0] addr_o,
  output mem_pkg::data_t          wdata_o,
  output mem_pkg::mask_t          mask_o,
  output logic                    src_o
);

  logic prio_r; // port that wins a tie.

  assign grant_a_o = req_v_a_i & (~prio_r | ~req_v_b_i);
  assign grant_b_o = req_v_b_i & (prio_r | ~req_v_a_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_r <= 1'b0;
    end else if (grant_a_o) begin
      prio_r <= 1'b1;
    end else if (grant_b_o) begin
      prio_r <= 1'b0;
    end
  end

  assign v_o     = req_v_a_i | req_v_b_i;
  assign src_o   = grant_b_o;
  assign we_o    = src_o ? req_we_b_i : req_we_a_i;
  assign addr_o  = src_o ? req_addr_b_i : req_addr_a_i;
  assign wdata_o = src_o ? req_wdata_b_i : req_wdata_a_i;
  assign mask_o  = src_o ? req_mask_b_i : req_mask_a_i;

  // a held request that loses once wins the next cycle.
  a_no_starve_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_v_a_i && !grant_a_o) |=> (!req_v_a_i || grant_a_o));

  a_no_starve_b: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_v_b_i && !grant_b_o) |=> (!req_v_b_i || grant_b_o));

endmodule

// ==== rtl/word_memory.sv ====
module word_memory #(
  parameter int addr_width_p = 12,
  parameter int mem_words_p  = 1024
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  input  logic                    we_i,
  input  logic [addr_width_p-3:0] addr_i,
  input  mem_pkg::data_t          wdata_i,
  input  mem_pkg::mask_t          mask_i,
  input  logic                    src_i,
  output logic                    rd_v_o,
  output logic                    rd_src_o,
  output mem_pkg::data_t          rd_data_o
);

  mem_pkg::data_t mem_r [mem_words_p];
  mem_pkg::data_t rd_data_r;
  logic           rd_v_r;
  logic           rd_src_r;

  // array starts from zero so unwritten words read back as zero.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_words_p; i++) begin
        mem_r[i] <= '0;
      end
    end else if (v_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (mask_i[b]) mem_r[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && !we_i) begin
      rd_data_r <= mem_r[addr_i];
    end else if (v_i) begin
      rd_data_r <= '0; // write acknowledge.
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r   <= 1'b0;
      rd_src_r <= 1'b0;
    end else begin
      rd_v_r   <= v_i;
      rd_src_r <= src_i;
    end
  end

  assign rd_v_o    = rd_v_r;
  assign rd_src_o  = rd_src_r;
  assign rd_data_o = rd_data_r;

endmodule

// ==== rtl/mem_subsys_top.sv ====
module mem_subsys_top #(
  parameter int addr_width_p    = 12,
  parameter int id_width_p      = 4,
  parameter int mem_words_p     = 1024,
  parameter int pending_depth_p = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_a_i,
  output logic                    ready_a_o,
  input  mem_pkg::op_e            op_a_i,
  input  logic [addr_width_p-1:0] addr_a_i,
  input  mem_pkg::data_t          data_a_i,
  input  logic [id_width_p-1:0]   id_a_i,
  output logic                    v_a_o,
  input  logic                    yumi_a_i,
  output logic [id_width_p-1:0]   id_a_o,
  output mem_pkg::data_t          data_a_o,
  input  logic                    v_b_i,
  output logic                    ready_b_o,
  input  mem_pkg::op_e            op_b_i,
  input  logic [addr_width_p-1:0] addr_b_i,
  input  mem_pkg::data_t          data_b_i,
  input  logic [id_width_p-1:0]   id_b_i,
  output logic                    v_b_o,
  input  logic                    yumi_b_i,
  output logic [id_width_p-1:0]   id_b_o,
  output mem_pkg::data_t          data_b_o
);

  logic                    mem_v_a;
  logic                    mem_we_a;
  logic [addr_width_p-3:0] mem_addr_a;
  mem_pkg::data_t          mem_wdata_a;
  mem_pkg::mask_t          mem_mask_a;
  logic                    grant_a;
  logic                    mem_v_b;
  logic                    mem_we_b;
  logic [addr_width_p-3:0] mem_addr_b;
  mem_pkg::data_t          mem_wdata_b;
  mem_pkg::mask_t          mem_mask_b;
  logic                    grant_b;

  logic                    iss_v;
  logic                    iss_we;
  logic [addr_width_p-3:0] iss_addr;
  mem_pkg::data_t          iss_wdata;
  mem_pkg::mask_t          iss_mask;
  logic                    iss_src;

  logic                    rd_v;
  logic                    rd_src;
  mem_pkg::data_t          rd_data;

  client_port #(
    .addr_width_p(addr_width_p),
    .id_width_p(id_width_p),
    .pending_depth_p(pending_depth_p),
    .port_id_p(0)
  ) u_port_a (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_a_i), .ready_o(ready_a_o), .op_i(op_a_i),
    .addr_i(addr_a_i), .data_i(data_a_i), .id_i(id_a_i),
    .v_o(v_a_o), .yumi_i(yumi_a_i), .id_o(id_a_o), .data_o(data_a_o),
    .mem_v_o(mem_v_a), .grant_i(grant_a), .mem_we_o(mem_we_a),
    .mem_addr_o(mem_addr_a), .mem_wdata_o(mem_wdata_a), .mem_mask_o(mem_mask_a),
    .rd_v_i(rd_v), .rd_src_i(rd_src), .rd_data_i(rd_data)
  );

  client_port #(
    .addr_width_p(addr_width_p),
    .id_width_p(id_width_p),
    .pending_depth_p(pending_depth_p),
    .port_id_p(1)
  ) u_port_b (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_b_i), .ready_o(ready_b_o), .op_i(op_b_i),
    .addr_i(addr_b_i), .data_i(data_b_i), .id_i(id_b_i),
    .v_o(v_b_o), .yumi_i(yumi_b_i), .id_o(id_b_o), .data_o(data_b_o),
    .mem_v_o(mem_v_b), .grant_i(grant_b), .mem_we_o(mem_we_b),
    .mem_addr_o(mem_addr_b), .mem_wdata_o(mem_wdata_b), .mem_mask_o(mem_mask_b),
    .rd_v_i(rd_v), .rd_src_i(rd_src), .rd_data_i(rd_data)
  );

  rr_arbiter #(
    .addr_width_p(addr_width_p)
  ) u_arb (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_v_a_i(mem_v_a), .req_we_a_i(mem_we_a), .req_addr_a_i(mem_addr_a),
    .req_wdata_a_i(mem_wdata_a), .req_mask_a_i(mem_mask_a), .grant_a_o(grant_a),
    .req_v_b_i(mem_v_b), .req_we_b_i(mem_we_b), .req_addr_b_i(mem_addr_b),
    .req_wdata_b_i(mem_wdata_b), .req_mask_b_i(mem_mask_b), .grant_b_o(grant_b),
    .v_o(iss_v), .we_o(iss_we), .addr_o(iss_addr),
    .wdata_o(iss_wdata), .mask_o(iss_mask), .src_o(iss_src)
  );

  word_memory #(
    .addr_width_p(addr_width_p),
    .mem_words_p(mem_words_p)
  ) u_mem (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(iss_v), .we_i(iss_we), .addr_i(iss_addr),
    .wdata_i(iss_wdata), .mask_i(iss_mask), .src_i(iss_src),
    .rd_v_o(rd_v), .rd_src_o(rd_src), .rd_data_o(rd_data)
  );

endmodule

// ==== bench/clock_gen.sv ====
module clock_gen #(
  parameter int reset_cycles_p = 2
) (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // 4 ns period.
  end

  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== bench/shadow_checker.sv ====
module shadow_checker #(
  parameter int id_width_p = 4,
  parameter     port_tag_p = "a"
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  v_i,
  input logic                  yumi_i,
  input logic [id_width_p-1:0] id_i,
  input mem_pkg::data_t        data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // expected responses in acceptance order.
  logic [id_width_p-1:0] exp_id_q [$];
  mem_pkg::data_t        exp_data_q [$];
  logic [id_width_p-1:0] exp_id;
  mem_pkg::data_t        exp_data;
  int                    err_cnt = 0;
  int                    check_cnt = 0;

  function automatic logic writes_memory(input mem_pkg::op_e op);
    case (op)
      mem_pkg::SW, mem_pkg::SH, mem_pkg::SB: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // selected lane, then sign or zero extension.
  function automatic mem_pkg::data_t load_value(input mem_pkg::op_e op, input logic [1:0] off,
                                                input mem_pkg::data_t word);
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    lane_byte = 8'(word >> (8 * off));
    lane_half = 16'(word >> (16 * off[1])); // half-word ignores bit 0.
    case (op)
      mem_pkg::LW:  return word;
      mem_pkg::LH:  return {{16{lane_half[15]}}, lane_half};
      mem_pkg::LHU: return {16'h0000, lane_half};
      mem_pkg::LB:  return {{24{lane_byte[7]}}, lane_byte};
      mem_pkg::LBU: return {24'h000000, lane_byte};
      default:      return '0;
    endcase
  endfunction

  function automatic mem_pkg::data_t merge_store(input mem_pkg::op_e op, input logic [1:0] off,
                                                 input mem_pkg::data_t data,
                                                 input mem_pkg::data_t word);
    mem_pkg::data_t merged;
    merged = word;
    for (int lane = 0; lane < 4; lane++) begin
      case (op)
        mem_pkg::SW: merged[8*lane +: 8] = data[8*lane +: 8];
        mem_pkg::SH: if (lane / 2 == off[1]) merged[8*lane +: 8] = data[8*(lane%2) +: 8];
        mem_pkg::SB: if (lane == off) merged[8*lane +: 8] = data[7:0];
        default: ;
      endcase
    end
    return merged;
  endfunction

  // word holds the shadow word at acceptance and returns it updated.
  task automatic record_request(input mem_pkg::op_e op, input logic [1:0] off,
                                input mem_pkg::data_t data, input logic [id_width_p-1:0] id,
                                inout mem_pkg::data_t word);
    exp_id_q.push_back(id);
    if (writes_memory(op)) begin
      exp_data_q.push_back('0); // stores answer with zero.
      word = merge_store(op, off, data, word);
    end else begin
      exp_data_q.push_back(load_value(op, off, word));
    end
  endtask

  function automatic int outstanding();
    return exp_id_q.size();
  endfunction

  // sampled on the falling edge, the transfer lands on the next rising edge.
  always @(negedge clk_i) begin
    if (!reset_i && v_i && yumi_i) begin
      if (exp_id_q.size() == 0) begin
        err_cnt++;
        $display("Port %s returned a response at %0t with no request outstanding.",
                 port_tag_p, $time);
      end else begin
        exp_id   = exp_id_q.pop_front();
        exp_data = exp_data_q.pop_front();
        check_cnt += 2;
        assert (id_i === exp_id) else begin
          err_cnt++;
          $display("FAILED at %0t: id_%s_o expected %h, got %h", $time, port_tag_p,
                   exp_id, id_i);
        end
        assert (data_i === exp_data) else begin
          err_cnt++;
          $display("FAILED at %0t: data_%s_o expected %h, got %h", $time, port_tag_p,
                   exp_data, data_i);
        end
      end
    end
  end

endmodule

// ==== bench/tb_top.sv ====
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int addr_width_lp    = 12;
  localparam int id_width_lp      = 4;
  localparam int mem_words_lp     = 1024;
  localparam int pending_depth_lp = 4;

  typedef struct packed {
    logic [id_width_lp-1:0]   id;
    mem_pkg::op_e             op;
    logic [addr_width_lp-1:0] addr;
    mem_pkg::data_t           data;
  } req_t;

  logic clk;
  logic reset;

  logic                     v_a_i, ready_a_o, v_a_o, yumi_a_i;
  mem_pkg::op_e             op_a_i;
  logic [addr_width_lp-1:0] addr_a_i;
  mem_pkg::data_t           data_a_i, data_a_o;
  logic [id_width_lp-1:0]   id_a_i, id_a_o;
  logic                     v_b_i, ready_b_o, v_b_o, yumi_b_i;
  mem_pkg::op_e             op_b_i;
  logic [addr_width_lp-1:0] addr_b_i;
  mem_pkg::data_t           data_b_i, data_b_o;
  logic [id_width_lp-1:0]   id_b_i, id_b_o;

  req_t                   req_a_q [$];
  req_t                   req_b_q [$];
  req_t                   cur_a, cur_b;   // payload on each request port.
  logic                   fire_a, fire_b; // transfer at the coming rising edge.
  logic [id_width_lp-1:0] next_id_a, next_id_b;
  mem_pkg::data_t         shadow_mem [mem_words_lp];
  logic [31:0]            lfsr_r;
  int                     accepted_a, errors, checks, timeouts;
  bit                     timed_out;

  clock_gen u_clk (.clk_o(clk), .reset_o(reset));

  mem_subsys_top #(
    .addr_width_p(addr_width_lp),
    .id_width_p(id_width_lp),
    .mem_words_p(mem_words_lp),
    .pending_depth_p(pending_depth_lp)
  ) UUT (
    .clk_i(clk), .reset_i(reset),
    .v_a_i(v_a_i), .ready_a_o(ready_a_o), .op_a_i(op_a_i), .addr_a_i(addr_a_i),
    .data_a_i(data_a_i), .id_a_i(id_a_i), .v_a_o(v_a_o), .yumi_a_i(yumi_a_i),
    .id_a_o(id_a_o), .data_a_o(data_a_o),
    .v_b_i(v_b_i), .ready_b_o(ready_b_o), .op_b_i(op_b_i), .addr_b_i(addr_b_i),
    .data_b_i(data_b_i), .id_b_i(id_b_i), .v_b_o(v_b_o), .yumi_b_i(yumi_b_i),
    .id_b_o(id_b_o), .data_b_o(data_b_o)
  );

  shadow_checker #(.id_width_p(id_width_lp), .port_tag_p("a")) chk_a (
    .clk_i(clk), .reset_i(reset), .v_i(v_a_o), .yumi_i(yumi_a_i), .id_i(id_a_o),
    .data_i(data_a_o)
  );

  shadow_checker #(.id_width_p(id_width_lp), .port_tag_p("b")) chk_b (
    .clk_i(clk), .reset_i(reset), .v_i(v_b_o), .yumi_i(yumi_b_i), .id_i(id_b_o),
    .data_i(data_b_o)
  );

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic is_write(input mem_pkg::op_e op);
    return (op == mem_pkg::SW) || (op == mem_pkg::SH) || (op == mem_pkg::SB);
  endfunction

  // same word with a store on either side; such pairs must not be accepted together.
  function automatic logic word_hazard(input req_t x, input req_t y);
    return (x.addr[addr_width_lp-1:2] == y.addr[addr_width_lp-1:2]) &&
           (is_write(x.op) || is_write(y.op));
  endfunction

  function automatic logic traffic_done();
    return (req_a_q.size() == 0) && (req_b_q.size() == 0) &&
           !(v_a_i && !fire_a) && !(v_b_i && !fire_b) &&
           (chk_a.outstanding() == 0) && (chk_b.outstanding() == 0);
  endfunction

  task automatic check_value(input string name, input mem_pkg::data_t expected,
                             input mem_pkg::data_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("Timeout at %0t: %s.", $time, what);
  endtask

  task automatic queue_request(input bit port_b, input mem_pkg::op_e op,
                               input logic [addr_width_lp-1:0] addr, input mem_pkg::data_t data);
    req_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    if (port_b) begin
      r.id = next_id_b;
      next_id_b++;
      req_b_q.push_back(r);
    end else begin
      r.id = next_id_a;
      next_id_a++;
      req_a_q.push_back(r);
    end
  endtask

  task automatic record_accept(input bit port_b, input req_t r);
    logic [addr_width_lp-3:0] w;
    mem_pkg::data_t           word;
    w    = r.addr[addr_width_lp-1:2];
    word = shadow_mem[w];
    if (port_b) chk_b.record_request(r.op, r.addr[1:0], r.data, r.id, word);
    else chk_a.record_request(r.op, r.addr[1:0], r.data, r.id, word);
    shadow_mem[w] = word;
  endtask

  // one clock with drives at the rising edge and handshake samples at the falling edge.
  task automatic step_cycle(input bit hold_yumi_a, input bit random_yumi);
    logic next_v_a;
    logic next_v_b;
    @(posedge clk);
    next_v_a = v_a_i && !fire_a; // a held request keeps its payload.
    next_v_b = v_b_i && !fire_b;
    if (!next_v_a && req_a_q.size() > 0) begin
      if (!(next_v_b && word_hazard(req_a_q[0], cur_b))) begin
        cur_a    = req_a_q.pop_front();
        next_v_a = 1'b1;
      end
    end
    if (!next_v_b && req_b_q.size() > 0) begin
      if (!(next_v_a && word_hazard(req_b_q[0], cur_a))) begin
        cur_b    = req_b_q.pop_front();
        next_v_b = 1'b1;
      end
    end
    v_a_i    <= next_v_a;
    op_a_i   <= cur_a.op;
    addr_a_i <= cur_a.addr;
    data_a_i <= cur_a.data;
    id_a_i   <= cur_a.id;
    v_b_i    <= next_v_b;
    op_b_i   <= cur_b.op;
    addr_b_i <= cur_b.addr;
    data_b_i <= cur_b.data;
    id_b_i   <= cur_b.id;
    yumi_a_i <= hold_yumi_a ? 1'b0 : (random_yumi ? (rand_bits(2) != 0) : 1'b1);
    yumi_b_i <= random_yumi ? (rand_bits(2) != 0) : 1'b1;
    @(negedge clk);
    fire_a = v_a_i && ready_a_o;
    fire_b = v_b_i && ready_b_o;
    if (fire_a) begin
      record_accept(1'b0, cur_a);
      accepted_a++;
    end
    if (fire_b) record_accept(1'b1, cur_b);
  endtask

  task automatic run_until_drained(input bit random_yumi, input int max_cycles);
    int cycles;
    cycles = 0;
    while (!timed_out && !traffic_done()) begin
      step_cycle(1'b0, random_yumi);
      cycles++;
      if (cycles > max_cycles) report_timeout("the request traffic did not drain");
    end
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!timed_out && reset) begin
      @(negedge clk);
      cycles++;
      if (cycles > 10) report_timeout("reset was never released");
    end
  endtask

  task automatic reset_state_loads();
    for (int i = 0; i < 3; i++) begin
      step_cycle(1'b0, 1'b0);
      check_value("v_a_o", 1'b0, v_a_o);
      check_value("v_b_o", 1'b0, v_b_o);
      check_value("ready_a_o", 1'b1, ready_a_o);
      check_value("ready_b_o", 1'b1, ready_b_o);
    end
    for (int i = 0; i < 6; i++) begin
      queue_request(1'b0, mem_pkg::LW, addr_width_lp'(rand_bits(addr_width_lp)), '0);
      queue_request(1'b1, mem_pkg::op_e'(rand_bits(2)),
                    addr_width_lp'(rand_bits(addr_width_lp)), '0);
    end
    run_until_drained(1'b0, 200);
  endtask

  task automatic word_store_load();
    logic [addr_width_lp-1:0] a0;
    logic [addr_width_lp-1:0] a1;
    a0 = {(addr_width_lp - 2)'(rand_bits(addr_width_lp - 2)), 2'b00};
    a1 = a0 ^ 12'h004; // the neighbouring word.
    queue_request(1'b0, mem_pkg::SW, a0, rand_bits(32));
    queue_request(1'b0, mem_pkg::LW, a0, '0);
    queue_request(1'b0, mem_pkg::SW, a1, rand_bits(32));
    queue_request(1'b0, mem_pkg::SW, a0, rand_bits(32));
    queue_request(1'b0, mem_pkg::LW, a1, '0);
    queue_request(1'b0, mem_pkg::LW, a0, '0);
    run_until_drained(1'b0, 200);
  endtask

  task automatic sub_word_access();
    logic [addr_width_lp-1:0] base;
    base = {(addr_width_lp - 2)'(rand_bits(addr_width_lp - 2)), 2'b00};
    queue_request(1'b1, mem_pkg::SW, base, 32'hf08a_7f01); // both sign cases per lane.
    for (int off = 0; off < 4; off++) begin
      queue_request(1'b1, mem_pkg::LB, base | addr_width_lp'(off), '0);
      queue_request(1'b1, mem_pkg::LBU, base | addr_width_lp'(off), '0);
      queue_request(1'b1, mem_pkg::LH, base | addr_width_lp'(off), '0);
      queue_request(1'b1, mem_pkg::LHU, base | addr_width_lp'(off), '0);
    end
    for (int off = 0; off < 4; off++) begin
      queue_request(1'b1, mem_pkg::SB, base | addr_width_lp'(off), rand_bits(32));
      queue_request(1'b1, mem_pkg::LW, base, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      queue_request(1'b1, mem_pkg::SH, base | addr_width_lp'(off), rand_bits(32));
      queue_request(1'b1, mem_pkg::LW, base, '0);
      queue_request(1'b1, mem_pkg::LH, base | addr_width_lp'(off), '0);
      queue_request(1'b1, mem_pkg::LHU, base | addr_width_lp'(off), '0);
    end
    run_until_drained(1'b0, 400);
  endtask

  task automatic both_ports_shared();
    for (int i = 0; i < 24; i++) begin
      queue_request(1'b0, mem_pkg::op_e'(rand_bits(3)), addr_width_lp'(rand_bits(4)),
                    rand_bits(32));
      queue_request(1'b1, mem_pkg::op_e'(rand_bits(3)), addr_width_lp'(rand_bits(4)),
                    rand_bits(32));
    end
    run_until_drained(1'b0, 600);
  endtask

  task automatic back_pressure_hold();
    int base;
    int cycles;
    base   = accepted_a;
    cycles = 0;
    for (int i = 0; i < 2 * pending_depth_lp; i++) begin
      queue_request(1'b0, i[0] ? mem_pkg::LW : mem_pkg::SW, 12'h010, rand_bits(32));
    end
    while (!timed_out && !((accepted_a - base) >= pending_depth_lp && !ready_a_o)) begin
      step_cycle(1'b1, 1'b0);
      cycles++;
      if (cycles > 50) report_timeout("port a never filled while responses were held");
    end
    repeat (8) step_cycle(1'b1, 1'b0); // nothing more may get in.
    check_value("accepted count on port a", pending_depth_lp, accepted_a - base);
    check_value("ready_a_o", 1'b0, ready_a_o);
    check_value("v_a_o", 1'b1, v_a_o);
    run_until_drained(1'b0, 300);
  endtask

  task automatic random_mix();
    for (int i = 0; i < 160; i++) begin
      queue_request(1'b0, mem_pkg::op_e'(rand_bits(3)), addr_width_lp'(rand_bits(6)),
                    rand_bits(32));
      queue_request(1'b1, mem_pkg::op_e'(rand_bits(3)), addr_width_lp'(rand_bits(6)),
                    rand_bits(32));
    end
    run_until_drained(1'b1, 5000);
  endtask

  initial begin
    int total;
    v_a_i = 1'b0;
    op_a_i = mem_pkg::LW;
    addr_a_i = '0;
    data_a_i = '0;
    id_a_i = '0;
    v_b_i = 1'b0;
    op_b_i = mem_pkg::LW;
    addr_b_i = '0;
    data_b_i = '0;
    id_b_i = '0;
    yumi_a_i = 1'b0;
    yumi_b_i = 1'b0;
    cur_a = '0;
    cur_b = '0;
    fire_a = 1'b0;
    fire_b = 1'b0;
    next_id_a = '0;
    next_id_b = '0;
    lfsr_r = 32'h55d9;
    accepted_a = 0;
    errors = 0;
    checks = 0;
    timeouts = 0;
    timed_out = 1'b0;
    for (int i = 0; i < mem_words_lp; i++) shadow_mem[i] = '0; // memory clears at reset.
    wait_for_reset();
    if (!timed_out) reset_state_loads();
    if (!timed_out) word_store_load();
    if (!timed_out) sub_word_access();
    if (!timed_out) both_ports_shared();
    if (!timed_out) back_pressure_hold();
    if (!timed_out) random_mix();
    total = errors + chk_a.err_cnt + chk_b.err_cnt;
    $display("checks %0d, errors %0d, timeouts %0d",
             checks + chk_a.check_cnt + chk_b.check_cnt, total, timeouts);
    if (total == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/mem_pkg.sv
rtl/lane_align.sv
rtl/client_port.sv
rtl/rr_arbiter.sv
rtl/word_memory.sv
rtl/mem_subsys_top.sv
bench/clock_gen.sv
bench/shadow_checker.sv
bench/tb_top.sv
